// File: common/pipe_pkg.sv
package pipe_pkg;

    // Pipeline shape
    localparam int NUM_STAGES = 5;
    localparam int S_FETCH     = 0;
    localparam int S_DECODE    = 1;
    localparam int S_EXECUTE   = 2;
    localparam int S_MEMORY    = 3;
    localparam int S_WRITEBACK = 4;

    // Retirement log sizing
    localparam int LOG_DEPTH = 8;
    localparam int LOG_CNT_W = 4;
    localparam int LOG_PTR_W = $clog2(LOG_DEPTH);
    localparam int RETIRED_W = 16;

    typedef logic [7:0] tag_t;
    typedef logic [3:0] stall_cnt_t;
    typedef logic [7:0] latency_t;
    typedef logic [7:0] cycle_t;

    typedef logic [LOG_CNT_W-1:0] log_cnt_t;
    typedef logic [LOG_PTR_W-1:0] log_ptr_t;
    typedef logic [RETIRED_W-1:0] retired_cnt_t;

    // APB register map
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t ADDR_STATUS  = 4'h0;
    localparam apb_addr_t ADDR_RECORD  = 4'h4;
    localparam apb_addr_t ADDR_RETIRED = 4'h8;

    localparam int STATUS_OVF_BIT = 8;

endpackage

// File: pipeline/stage_control.sv
`timescale 1ns/1ps

module stage_control (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           issue_valid,
    input  pipe_pkg::tag_t issue_tag,
    output logic           issue_ready,
    output logic           fetch_load,
    output logic           hold_fetch,
    output logic           hold_decode,
    output logic           adv_decode,
    output logic           adv_execute,
    output logic           retire,
    output pipe_pkg::tag_t retire_tag
);

    logic [pipe_pkg::NUM_STAGES-1:0] valid;
    pipe_pkg::tag_t                  tag [pipe_pkg::NUM_STAGES];
    logic                            front_adv;

    // Only the front two stages see stall
    assign front_adv = !stall;

    assign issue_ready = (!valid[pipe_pkg::S_FETCH] || front_adv) && !stall;
    assign fetch_load  = issue_valid && issue_ready;

    assign hold_fetch  = stall && valid[pipe_pkg::S_FETCH];
    assign hold_decode = stall && valid[pipe_pkg::S_DECODE];

    // Load events for the stages fed from a stallable stage
    assign adv_decode  = front_adv && valid[pipe_pkg::S_FETCH];
    assign adv_execute = front_adv && valid[pipe_pkg::S_DECODE];

    // Writeback always drains, so a valid entry retires every cycle it is there
    assign retire     = valid[pipe_pkg::S_WRITEBACK];
    assign retire_tag = tag[pipe_pkg::S_WRITEBACK];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (front_adv) begin
                valid[pipe_pkg::S_FETCH]  <= fetch_load;
                valid[pipe_pkg::S_DECODE] <= valid[pipe_pkg::S_FETCH];
            end
            // Bubble enters execute while decode is frozen
            valid[pipe_pkg::S_EXECUTE] <= adv_execute;
            for (int s = pipe_pkg::S_MEMORY; s < pipe_pkg::NUM_STAGES; s++) begin
                valid[s] <= valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_load) begin
            tag[pipe_pkg::S_FETCH] <= issue_tag;
        end
        if (adv_decode) begin
            tag[pipe_pkg::S_DECODE] <= tag[pipe_pkg::S_FETCH];
        end
        if (adv_execute) begin
            tag[pipe_pkg::S_EXECUTE] <= tag[pipe_pkg::S_DECODE];
        end
        for (int s = pipe_pkg::S_MEMORY; s < pipe_pkg::NUM_STAGES; s++) begin
            tag[s] <= tag[s-1];
        end
    end

endmodule

// File: pipeline/instr_tracker.sv
`timescale 1ns/1ps

module instr_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_load,
    input  logic                 hold_fetch,
    input  logic                 hold_decode,
    input  logic                 adv_decode,
    input  logic                 adv_execute,
    input  logic                 retire,
    input  pipe_pkg::tag_t       retire_tag,
    output logic                 rec_valid,
    output pipe_pkg::tag_t       rec_tag,
    output pipe_pkg::stall_cnt_t rec_stalls,
    output pipe_pkg::latency_t   rec_latency
);

    pipe_pkg::cycle_t     cycle_cnt;
    pipe_pkg::cycle_t     stamp  [pipe_pkg::NUM_STAGES];
    pipe_pkg::stall_cnt_t stalls [pipe_pkg::NUM_STAGES];
    pipe_pkg::cycle_t     age;

    function automatic pipe_pkg::stall_cnt_t sat_inc(input pipe_pkg::stall_cnt_t cnt);
        pipe_pkg::stall_cnt_t result;
        if (cnt == '1) begin
            result = cnt;
        end else begin
            result = cnt + 1'b1;
        end
        return result;
    endfunction

    // Free-running stamp that wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Fetch side record
    always_ff @(posedge clk) begin
        if (fetch_load) begin
            stamp[pipe_pkg::S_FETCH]  <= cycle_cnt;
            stalls[pipe_pkg::S_FETCH] <= '0;
        end else if (hold_fetch) begin
            stalls[pipe_pkg::S_FETCH] <= sat_inc(stalls[pipe_pkg::S_FETCH]);
        end
    end

    // Decode keeps counting on top of what fetch collected
    always_ff @(posedge clk) begin
        if (adv_decode) begin
            stamp[pipe_pkg::S_DECODE]  <= stamp[pipe_pkg::S_FETCH];
            stalls[pipe_pkg::S_DECODE] <= stalls[pipe_pkg::S_FETCH];
        end else if (hold_decode) begin
            stalls[pipe_pkg::S_DECODE] <= sat_inc(stalls[pipe_pkg::S_DECODE]);
        end
    end

    // Back stages never hold and the records just ride along
    always_ff @(posedge clk) begin
        if (adv_execute) begin
            stamp[pipe_pkg::S_EXECUTE]  <= stamp[pipe_pkg::S_DECODE];
            stalls[pipe_pkg::S_EXECUTE] <= stalls[pipe_pkg::S_DECODE];
        end
        for (int s = pipe_pkg::S_MEMORY; s < pipe_pkg::NUM_STAGES; s++) begin
            stamp[s]  <= stamp[s-1];
            stalls[s] <= stalls[s-1];
        end
    end

    // Modular difference of the two 8-bit stamps
    assign age = cycle_cnt - stamp[pipe_pkg::S_WRITEBACK];

    assign rec_valid   = retire;
    assign rec_tag     = retire_tag;
    assign rec_stalls  = stalls[pipe_pkg::S_WRITEBACK];
    assign rec_latency = pipe_pkg::latency_t'(age);

endmodule

// File: verilog/retire_log.sv
`timescale 1ns/1ps

module retire_log (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rec_valid,
    input  pipe_pkg::tag_t       rec_tag,
    input  pipe_pkg::stall_cnt_t rec_stalls,
    input  pipe_pkg::latency_t   rec_latency,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  pipe_pkg::apb_addr_t  paddr,
    input  pipe_pkg::apb_data_t  pwdata,
    output pipe_pkg::apb_data_t  prdata,
    output logic                 pready,
    output logic                 pslverr
);

    pipe_pkg::tag_t         mem_tag    [pipe_pkg::LOG_DEPTH];
    pipe_pkg::stall_cnt_t   mem_stalls [pipe_pkg::LOG_DEPTH];
    pipe_pkg::latency_t     mem_lat    [pipe_pkg::LOG_DEPTH];
    pipe_pkg::log_ptr_t     wr_ptr;
    pipe_pkg::log_ptr_t     rd_ptr;
    pipe_pkg::log_cnt_t     count;
    pipe_pkg::retired_cnt_t retired;
    logic                   overflow;
    logic                   access;
    logic                   rd_access;
    logic                   wr_access;
    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;
    logic                   ovf_clear;
    pipe_pkg::apb_data_t    record_word;
    pipe_pkg::apb_data_t    status_word;

    assign access    = psel && penable;
    assign rd_access = access && !pwrite;
    assign wr_access = access && pwrite;

    assign full  = (count == pipe_pkg::log_cnt_t'(pipe_pkg::LOG_DEPTH));
    assign empty = (count == '0);
    // A full FIFO drops the record and the pipeline never waits
    assign push  = rec_valid && !full;
    assign pop   = rd_access && (paddr == pipe_pkg::ADDR_RECORD) && !empty;

    assign ovf_clear = wr_access && (paddr == pipe_pkg::ADDR_STATUS)
                       && pwdata[pipe_pkg::STATUS_OVF_BIT];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_tag[wr_ptr]    <= rec_tag;
            mem_stalls[wr_ptr] <= rec_stalls;
            mem_lat[wr_ptr]    <= rec_latency;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
            retired  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // A new drop wins over a clear in the same cycle
            if (rec_valid && full) begin
                overflow <= 1'b1;
            end else if (ovf_clear) begin
                overflow <= 1'b0;
            end
            if (rec_valid) begin
                retired <= retired + 1'b1;
            end
        end
    end

    // Tag in 7:0 with stalls in 11:8 and latency in 23:16
    assign record_word = empty ? '0 :
        {8'h00, mem_lat[rd_ptr], 4'h0, mem_stalls[rd_ptr], mem_tag[rd_ptr]};
    assign status_word = pipe_pkg::apb_data_t'(count)
                         | (pipe_pkg::apb_data_t'(overflow) << pipe_pkg::STATUS_OVF_BIT);

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                pipe_pkg::ADDR_STATUS:  prdata = status_word;
                pipe_pkg::ADDR_RECORD:  prdata = record_word;
                pipe_pkg::ADDR_RETIRED: prdata = pipe_pkg::apb_data_t'(retired);
                default:                prdata = '0;
            endcase
        end
    end

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && !(paddr inside {pipe_pkg::ADDR_STATUS, pipe_pkg::ADDR_RECORD,
                                               pipe_pkg::ADDR_RETIRED});

endmodule

// File: verilog/pipe_top.sv
`timescale 1ns/1ps

module pipe_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                issue_valid,
    input  pipe_pkg::tag_t      issue_tag,
    output logic                issue_ready,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  pipe_pkg::apb_addr_t paddr,
    input  pipe_pkg::apb_data_t pwdata,
    output pipe_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr
);

    logic                   fetch_load;
    logic                   hold_fetch;
    logic                   hold_decode;
    logic                   adv_decode;
    logic                   adv_execute;
    logic                   retire;
    pipe_pkg::tag_t         retire_tag;

    logic                   rec_valid;
    pipe_pkg::tag_t         rec_tag;
    pipe_pkg::stall_cnt_t   rec_stalls;
    pipe_pkg::latency_t     rec_latency;

    stage_control u_stage_control (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_ready (issue_ready),
        .fetch_load  (fetch_load),
        .hold_fetch  (hold_fetch),
        .hold_decode (hold_decode),
        .adv_decode  (adv_decode),
        .adv_execute (adv_execute),
        .retire      (retire),
        .retire_tag  (retire_tag)
    );

    instr_tracker u_instr_tracker (
        .clk         (clk),
        .rst         (rst),
        .fetch_load  (fetch_load),
        .hold_fetch  (hold_fetch),
        .hold_decode (hold_decode),
        .adv_decode  (adv_decode),
        .adv_execute (adv_execute),
        .retire      (retire),
        .retire_tag  (retire_tag),
        .rec_valid   (rec_valid),
        .rec_tag     (rec_tag),
        .rec_stalls  (rec_stalls),
        .rec_latency (rec_latency)
    );

    retire_log u_retire_log (
        .clk         (clk),
        .rst         (rst),
        .rec_valid   (rec_valid),
        .rec_tag     (rec_tag),
        .rec_stalls  (rec_stalls),
        .rec_latency (rec_latency),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

endmodule

// File: testbench/pipe_sva.sv
`timescale 1ns/1ps

module pipe_sva (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic issue_ready,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr
);

    int fail_count;

    initial fail_count = 0;

    // Stall is the only back-pressure on issue
    stall_blocks_issue: assert property (@(posedge clk) disable iff (rst) stall |-> !issue_ready)
        else begin
            $error("issue_ready high while stall is high");
            fail_count++;
        end

    // Slave has no wait states
    pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            $error("pready low");
            fail_count++;
        end

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
                                       pslverr |-> (psel && penable))
        else begin
            $error("pslverr high outside an access cycle");
            fail_count++;
        end

endmodule

bind pipe_top pipe_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .issue_ready (issue_ready),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr)
);

// File: testbench/pipe_tb.sv
`timescale 1ns/1ps

module pipe_tb;

    localparam int TIMEOUT = 100;

    logic                clk;
    logic                rst;
    logic                stall;
    logic                issue_valid;
    pipe_pkg::tag_t      issue_tag;
    logic                issue_ready;
    logic                psel;
    logic                penable;
    logic                pwrite;
    pipe_pkg::apb_addr_t paddr;
    pipe_pkg::apb_data_t pwdata;
    pipe_pkg::apb_data_t prdata;
    logic                pready;
    logic                pslverr;

    int errors;
    int checks;
    int seed;

    // Reference model of every issued tag and its expected stall count
    pipe_pkg::tag_t       m_tag [$];
    pipe_pkg::stall_cnt_t m_stalls [$];
    int                   exp_q [$];
    int                   f_idx;
    int                   d_idx;

    pipe_top dut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_ready (issue_ready),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    always #10 clk = ~clk;

    task automatic check_tag(input string name, input pipe_pkg::tag_t got,
                             input pipe_pkg::tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_stalls(input string name, input pipe_pkg::stall_cnt_t got,
                                input pipe_pkg::stall_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input pipe_pkg::latency_t got,
                                 input pipe_pkg::latency_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input pipe_pkg::apb_data_t got,
                              input pipe_pkg::apb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        stall = 1'b0;
        issue_valid = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        m_tag.delete();
        m_stalls.delete();
        exp_q.delete();
        f_idx = -1;
        d_idx = -1;
    endtask

    task automatic count_stall(input int idx);
        if (idx >= 0) begin
            if (m_stalls[idx] != 4'hF) begin
                m_stalls[idx] = m_stalls[idx] + 4'd1;
            end
        end
    endtask

    task automatic issue(input pipe_pkg::tag_t t);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        issue_valid = 1'b1;
        issue_tag = t;
        stall = 1'b0;
        #1;
        while (!issue_ready && wait_cnt < TIMEOUT) begin
            wait_cnt++;
            @(posedge clk);
            #1;
        end
        if (!issue_ready) begin
            errors++;
            $display("Issue of tag %h timed out waiting for issue_ready", t);
        end else begin
            @(posedge clk);
            // Front stages shift and the new tag lands in fetch
            d_idx = f_idx;
            f_idx = m_tag.size();
            exp_q.push_back(f_idx);
            m_tag.push_back(t);
            m_stalls.push_back(4'h0);
        end
    endtask

    task automatic run_cycles(input int n, input logic stalled);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            issue_valid = 1'b0;
            stall = stalled;
            @(posedge clk);
            if (stalled) begin
                count_stall(f_idx);
                count_stall(d_idx);
            end else begin
                d_idx = f_idx;
                f_idx = -1;
            end
        end
    endtask

    task automatic apb_xfer(input logic write, input pipe_pkg::apb_addr_t addr,
                            input pipe_pkg::apb_data_t wdata,
                            output pipe_pkg::apb_data_t rdata, output logic err);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready && wait_cnt < TIMEOUT) begin
            wait_cnt++;
            @(posedge clk);
            #1;
        end
        if (!pready) begin
            errors++;
            $display("APB access to address %h timed out waiting for pready", addr);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input pipe_pkg::apb_addr_t addr, output pipe_pkg::apb_data_t data,
                            output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic apb_write(input pipe_pkg::apb_addr_t addr, input pipe_pkg::apb_data_t data,
                             output logic err);
        pipe_pkg::apb_data_t unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    // Retired counter is the done signal for a burst of issues
    task automatic wait_retired(input int n);
        pipe_pkg::apb_data_t data;
        logic                err;
        int                  polls;
        polls = 0;
        apb_read(pipe_pkg::ADDR_RETIRED, data, err);
        while (data != pipe_pkg::apb_data_t'(n) && polls < TIMEOUT) begin
            polls++;
            apb_read(pipe_pkg::ADDR_RETIRED, data, err);
        end
        if (data != pipe_pkg::apb_data_t'(n)) begin
            errors++;
            $display("Timed out waiting for %0d retirements", n);
        end
    endtask

    task automatic read_record();
        pipe_pkg::apb_data_t data;
        logic                err;
        int                  idx;
        pipe_pkg::latency_t  exp_lat;
        idx = exp_q.pop_front();
        apb_read(pipe_pkg::ADDR_RECORD, data, err);
        // Latency is the five stages plus every held cycle
        exp_lat = 8'd5 + {4'h0, m_stalls[idx]};
        check_tag("rec_tag", data[7:0], m_tag[idx]);
        check_stalls("rec_stalls", data[11:8], m_stalls[idx]);
        check_latency("rec_latency", data[23:16], exp_lat);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic check_status(input pipe_pkg::apb_data_t exp);
        pipe_pkg::apb_data_t data;
        logic                err;
        apb_read(pipe_pkg::ADDR_STATUS, data, err);
        check_data("status", data, exp);
    endtask

    task automatic test_reset_state();
        pipe_pkg::apb_data_t data;
        logic                err;
        apply_reset();
        #1;
        check_flag("issue_ready", issue_ready, 1'b1);
        check_status(32'h0);
        apb_read(pipe_pkg::ADDR_RETIRED, data, err);
        check_data("retired", data, 32'h0);
    endtask

    task automatic test_back_to_back();
        pipe_pkg::apb_data_t data;
        logic                err;
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            issue(pipe_pkg::tag_t'(8'hA0 + i));
        end
        run_cycles(6, 1'b0);
        wait_retired(4);
        check_status(pipe_pkg::apb_data_t'(exp_q.size()));
        for (int i = 0; i < 4; i++) begin
            read_record();
        end
        apb_read(pipe_pkg::ADDR_RETIRED, data, err);
        check_data("retired", data, 32'h4);
    endtask

    // Tag 0x31 sits in decode and 0x32 in fetch during the stall
    task automatic test_stall(input int n);
        apply_reset();
        issue(8'h31);
        issue(8'h32);
        run_cycles(n, 1'b1);
        issue(8'h33);
        run_cycles(6, 1'b0);
        wait_retired(3);
        for (int i = 0; i < 3; i++) begin
            read_record();
        end
    endtask

    task automatic test_overflow();
        pipe_pkg::apb_data_t data;
        logic                err;
        apply_reset();
        for (int i = 0; i < 10; i++) begin
            issue(pipe_pkg::tag_t'($random(seed)));
        end
        run_cycles(6, 1'b0);
        wait_retired(10);
        check_status(pipe_pkg::apb_data_t'(pipe_pkg::LOG_DEPTH) | 32'h100);
        for (int i = 0; i < pipe_pkg::LOG_DEPTH; i++) begin
            read_record();
        end
        // The last two arrived at a full FIFO and were dropped
        exp_q.delete();
        check_status(32'h100);
        apb_write(pipe_pkg::ADDR_STATUS, 32'h100, err);
        check_flag("pslverr", err, 1'b0);
        check_status(32'h0);
        apb_read(pipe_pkg::ADDR_RETIRED, data, err);
        check_data("retired", data, 32'ha);
    endtask

    task automatic test_empty_and_unmapped();
        pipe_pkg::apb_data_t data;
        logic                err;
        apply_reset();
        apb_read(pipe_pkg::ADDR_RECORD, data, err);
        check_data("record", data, 32'h0);
        check_flag("pslverr", err, 1'b0);
        apb_read(4'hC, data, err);
        check_data("prdata", data, 32'h0);
        check_flag("pslverr", err, 1'b1);
        apb_write(4'hC, 32'h1234, err);
        check_flag("pslverr", err, 1'b1);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        issue_valid = 1'b0;
        issue_tag = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        errors = 0;
        checks = 0;
        seed = 16;
        f_idx = -1;
        d_idx = -1;

        test_reset_state();
        test_back_to_back();
        test_stall(3);
        test_overflow();
        test_empty_and_unmapped();

        errors += dut.u_sva.fail_count;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
common/pipe_pkg.sv
pipeline/stage_control.sv
pipeline/instr_tracker.sv
verilog/retire_log.sv
verilog/pipe_top.sv
testbench/pipe_sva.sv
testbench/pipe_tb.sv

// File: Makefile
# Verilator simulation of the pipeline tracker

TOP := pipe_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
